/* filelist.f */
common/sampler_pkg.sv
uart_rx/uart_rx.sv
verilog/sample_loader.sv
verilog/sample_packer.sv
verilog/sample_store.sv
verilog/sample_loader_top.sv
test/sample_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module sample_loader_tb \
    -f filelist.f --Mdir obj_dir -o sample_loader_sim &&
./obj_dir/sample_loader_sim || { echo "simulation did not pass"; exit 1; }

/* test/sample_loader_tb.sv */
`timescale 1ns/100ps

module sample_loader_tb;
    import sampler_pkg::*;

    localparam int EXTRA_BYTES = 3 + 2 * SAMPLES_PER_WORD;    // one trailing record
    localparam int MARGIN_NS   = 4000;     // reset, readback and slack

    logic         clk;
    logic         rst;
    logic         uart_din;
    word_addr_t   rd_addr;
    word_t        rd_data;
    addr_starts_t addr_starts;
    logic         load_done;

    int           sizes [INSTRUMENT_COUNT];
    sample_t      samples [$];
    byte_t        stream [$];      // serial bytes in send order
    word_t        exp_mem [MEM_WORDS];
    addr_starts_t exp_starts;
    int           last_word;
    longint       cycle_cnt  = 0;
    longint       stop_cycle = 0;  // start of the latest stop bit
    longint       done_cycle = 0;
    bit           done_seen  = 1'b0;
    longint       limit_ns   = 0;

    sample_loader_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .uart_din    (uart_din),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .addr_starts (addr_starts),
        .load_done   (load_done)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ******************************************************************
    // helpers
    // ******************************************************************
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got %0h expected %0h", name, got, exp));
        end
    endtask

    // expected memory image and start words from sizes and samples
    function automatic void build_expected();
        int total;
        int word_idx;
        int lane;
        total = 0;
        exp_starts = '0;
        for (int w = 0; w < MEM_WORDS; w++) exp_mem[w] = '0;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            for (int s = 0; s < sizes[i]; s++) begin
                word_idx = total / SAMPLES_PER_WORD;
                lane     = total % SAMPLES_PER_WORD;
                exp_mem[word_idx][16 * lane +: 16] = samples[total];
                total++;
            end
            exp_starts[i + 1] = count_t'(total / SAMPLES_PER_WORD);
        end
        last_word = (total - 1) / SAMPLES_PER_WORD;
    endfunction

    task automatic wait_bit();
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    // 8N1 frame, lsb first
    task automatic send_byte(input byte_t b);
        uart_din = 1'b0;
        wait_bit();
        for (int i = 0; i < 8; i++) begin
            uart_din = b[i];
            wait_bit();
        end
        stop_cycle = cycle_cnt;
        uart_din   = 1'b1;
        wait_bit();
    endtask

    task automatic read_word(input int w, output word_t data);
        rd_addr = word_addr_t'(w);
        @(posedge clk);
        @(negedge clk);     // registered read lands here
        data = rd_data;
        @(posedge clk);
        #1;
    endtask

    task automatic check_image();
        word_t data;
        for (int w = 0; w <= last_word; w++) begin
            read_word(w, data);
            check_value($sformatf("rd_data[word %0d]", w), data, exp_mem[w]);
        end
        for (int i = 0; i <= INSTRUMENT_COUNT; i++) begin
            check_value($sformatf("addr_starts[%0d]", i),
                        word_t'(addr_starts[i]), word_t'(exp_starts[i]));
        end
    endtask

    // ******************************************************************
    // watchdog and load_done monitor
    // ******************************************************************
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        fail_run("Timeout: the sample load never finished");
    end

    always @(negedge clk) begin
        if (!rst && load_done && !done_seen) begin
            done_seen  = 1'b1;
            done_cycle = cycle_cnt;
        end else if (done_seen && !load_done) begin
            fail_run("load_done fell after it had been set");
        end
    end

    initial begin
        sample_t s;
        int      n;
        void'($urandom(98928));
        clk      = 1'b0;
        rst      = 1'b1;
        uart_din = 1'b1;    // idle line
        rd_addr  = '0;

        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            sizes[i] = 1 + int'($urandom % 40);
            stream.push_back(byte_t'(sizes[i]));
            stream.push_back(byte_t'(sizes[i] >> 8));
            stream.push_back(byte_t'(sizes[i] >> 16));
            for (int k = 0; k < sizes[i]; k++) begin
                s = sample_t'($urandom);
                samples.push_back(s);
                stream.push_back(s[7:0]);
                stream.push_back(s[15:8]);
            end
        end
        build_expected();
        limit_ns = longint'(stream.size() + EXTRA_BYTES) * 10 * CLKS_PER_BIT * 8 + MARGIN_NS;

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // idle state after reset
        @(negedge clk);
        check_value("load_done", word_t'(load_done), '0);
        for (int i = 0; i <= INSTRUMENT_COUNT; i++) begin
            check_value($sformatf("addr_starts[%0d]", i), word_t'(addr_starts[i]), '0);
        end
        @(posedge clk);
        #1;

        for (int b = 0; b < stream.size() - 1; b++) send_byte(stream[b]);
        check_value("load_done", word_t'(load_done), '0);
        send_byte(stream[stream.size() - 1]);

        n = 0;
        while (!done_seen && n < CLKS_PER_BIT + 3) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!done_seen) fail_run("load_done never rose after the final stop bit");
        if (done_cycle - stop_cycle > CLKS_PER_BIT + 3) begin
            fail_run($sformatf("load_done rose %0d cycles after the final stop bit began",
                               done_cycle - stop_cycle));
        end

        check_image();

        // trailing record of one full word must be ignored
        send_byte(byte_t'(SAMPLES_PER_WORD));
        send_byte(8'h00);
        send_byte(8'h00);
        for (int b = 0; b < 2 * SAMPLES_PER_WORD; b++) send_byte(byte_t'($urandom));
        check_image();
        check_value("load_done", word_t'(load_done), word_t'(1'b1));

        $display("all tests passed");
        $finish;
    end

endmodule

/* verilog/sample_loader_top.sv */
`timescale 1ns/100ps

module sample_loader_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        uart_din,
    input  sampler_pkg::word_addr_t     rd_addr,
    output sampler_pkg::word_t          rd_data,
    output sampler_pkg::addr_starts_t   addr_starts,
    output logic                        load_done
);
    import sampler_pkg::*;

    byte_t        rx_byte;
    logic         rx_valid;
    sample_beat_t beat;
    logic         beat_valid;
    mem_write_t   wr;
    logic         wr_valid;

    // ******************************************************************
    // serial link to byte stream
    // ******************************************************************
    uart_rx uart_rx_i (
        .clk      (clk),
        .rst      (rst),
        .din      (uart_din),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    sample_loader sample_loader_i (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .beat        (beat),
        .beat_valid  (beat_valid),
        .addr_starts (addr_starts)
    );

    // ******************************************************************
    // beats to memory words
    // ******************************************************************
    sample_packer sample_packer_i (
        .clk        (clk),
        .rst        (rst),
        .beat       (beat),
        .beat_valid (beat_valid),
        .wr         (wr),
        .wr_valid   (wr_valid),
        .load_done  (load_done)
    );

    sample_store sample_store_i (
        .clk      (clk),
        .wr       (wr),
        .wr_valid (wr_valid),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

/* verilog/sample_store.sv */
`timescale 1ns/100ps

module sample_store (
    input  logic                        clk,
    input  sampler_pkg::mem_write_t     wr,
    input  logic                        wr_valid,
    input  sampler_pkg::word_addr_t     rd_addr,
    output sampler_pkg::word_t          rd_data
);
    import sampler_pkg::*;

    // ******************************************************************
    // sample memory, one word per eight samples
    // ******************************************************************
    word_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read for the playback side
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/sample_packer.sv */
`timescale 1ns/100ps

module sample_packer (
    input  logic                        clk,
    input  logic                        rst,
    input  sampler_pkg::sample_beat_t   beat,
    input  logic                        beat_valid,
    output sampler_pkg::mem_write_t     wr,
    output logic                        wr_valid,
    output logic                        load_done
);
    import sampler_pkg::*;

    localparam int LANE_W = $clog2(SAMPLES_PER_WORD);
    localparam int SAMPLE_W = $bits(sample_t);

    logic [LANE_W-1:0] lane;
    word_t             word;
    word_addr_t        addr;
    word_t             merged;      // current word with this beat in place
    logic              flush;
    logic              final_wr;

    always_comb begin
        merged = word;
        merged[lane * SAMPLE_W +: SAMPLE_W] = beat.data;   // lane 0 in low bits
    end

    assign flush = beat_valid && (beat.last || lane == LANE_W'(SAMPLES_PER_WORD - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            lane      <= '0;
            word      <= '0;
            addr      <= '0;
            wr_valid  <= 1'b0;
            final_wr  <= 1'b0;
            load_done <= 1'b0;
        end else begin
            wr_valid <= flush;
            if (flush) begin
                wr.addr  <= addr;
                wr.data  <= merged;
                final_wr <= beat.last;
                word     <= '0;     // unused lanes of a partial word stay zero
                lane     <= '0;
                addr     <= addr + 1'b1;
            end else if (beat_valid) begin
                word <= merged;
                lane <= lane + 1'b1;
            end
            if (wr_valid && final_wr) load_done <= 1'b1;
        end
    end

endmodule

/* verilog/sample_loader.sv */
`timescale 1ns/100ps

module sample_loader (
    input  logic                        clk,
    input  logic                        rst,
    input  sampler_pkg::byte_t          rx_byte,
    input  logic                        rx_valid,
    output sampler_pkg::sample_beat_t   beat,
    output logic                        beat_valid,
    output sampler_pkg::addr_starts_t   addr_starts
);
    import sampler_pkg::*;

    localparam int IDX_W   = $clog2(INSTRUMENT_COUNT + 1);
    localparam int SHIFT_W = $clog2(SAMPLES_PER_WORD);

    typedef enum logic [1:0] {
        st_size,
        st_sample,
        st_done
    } load_state_t;

    load_state_t      state;
    logic [1:0]       size_byte;    // count bytes seen so far
    count_t           sample_size;
    logic             msb_phase;    // next byte is the sample msb
    byte_t            lsb_byte;
    count_t           sample_cnt;
    count_t           total_cnt;
    logic [IDX_W-1:0] inst_idx;

    count_t           sample_next;
    count_t           total_next;
    logic             inst_end;
    logic             final_inst;

    assign sample_next = sample_cnt + count_t'(1);
    assign total_next  = total_cnt + count_t'(1);
    assign inst_end    = (sample_next == sample_size);
    assign final_inst  = (inst_idx == IDX_W'(INSTRUMENT_COUNT - 1));

    // ******************************************************************
    // control
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_size;
            size_byte   <= '0;
            sample_size <= '0;
            msb_phase   <= 1'b0;
            sample_cnt  <= '0;
            total_cnt   <= '0;
            inst_idx    <= '0;
            beat_valid  <= 1'b0;
            addr_starts <= '0;
        end else begin
            beat_valid <= 1'b0;
            case (state)
                st_size: begin
                    if (rx_valid) begin
                        sample_size <= {rx_byte, sample_size[23:8]};   // lsb first
                        size_byte   <= size_byte + 1'b1;
                        if (size_byte == 2'd2) begin
                            size_byte  <= '0;
                            msb_phase  <= 1'b0;
                            sample_cnt <= '0;
                            state      <= st_sample;
                        end
                    end
                end
                st_sample: begin
                    if (rx_valid) begin
                        msb_phase <= ~msb_phase;
                        if (msb_phase) begin
                            beat_valid <= 1'b1;
                            sample_cnt <= sample_next;
                            total_cnt  <= total_next;
                            if (inst_end) begin
                                // start word of the next instrument
                                addr_starts[inst_idx + 1'b1] <= total_next >> SHIFT_W;
                                inst_idx <= inst_idx + 1'b1;
                                state    <= final_inst ? st_done : st_size;
                            end
                        end
                    end
                end
                st_done: ;  // later bytes are ignored
                default: state <= st_size;
            endcase
        end
    end

    // ******************************************************************
    // beat payload
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rx_valid && state == st_sample) begin
            if (msb_phase) begin
                beat.data <= {rx_byte, lsb_byte};
                beat.last <= inst_end && final_inst;
            end else begin
                lsb_byte <= rx_byte;
            end
        end
    end

endmodule

/* uart_rx/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                din,
    output sampler_pkg::byte_t  rx_byte,
    output logic                rx_valid
);
    import sampler_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [1:0]       din_sync;     // line idles high
    logic             din_s;

    assign din_s = din_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rx_idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            din_sync <= 2'b11;
            rx_valid <= 1'b0;
        end else begin
            din_sync <= {din_sync[0], din};
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (!din_s) state <= rx_start;
                end
                rx_start: begin
                    // confirm start bit at its centre
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= din_s ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        rx_valid <= din_s;  // drop frame on bad stop bit
                        state    <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == rx_data && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            rx_byte <= {din_s, rx_byte[7:1]};
        end
    end

endmodule

/* common/sampler_pkg.sv */
package sampler_pkg;

    // ******************************************************************
    // load parameters
    // ******************************************************************
    localparam int INSTRUMENT_COUNT = 3;
    localparam int CLKS_PER_BIT     = 16;   // short bit time for simulation
    localparam int SAMPLES_PER_WORD = 8;
    localparam int MEM_WORDS        = 64;

    // ******************************************************************
    // vector types
    // ******************************************************************
    typedef logic [7:0]   byte_t;
    typedef logic [15:0]  sample_t;
    typedef logic [23:0]  count_t;
    typedef logic [127:0] word_t;
    typedef logic [5:0]   word_addr_t;

    // one start word per instrument, plus end of the last one
    typedef count_t [INSTRUMENT_COUNT:0] addr_starts_t;

    // ******************************************************************
    // link structs
    // ******************************************************************
    typedef struct packed {
        sample_t data;
        logic    last;      // final sample of final instrument
    } sample_beat_t;

    typedef struct packed {
        word_addr_t addr;
        word_t      data;
    } mem_write_t;

endpackage
